// ==== design/mips_config.svh ====
`ifndef MIPS_CONFIG_SVH
`define MIPS_CONFIG_SVH

// First fetch address after reset, as on a real MIPS boot ROM.
`define MIPS_RESET_VECTOR 32'hBFC00000

// General purpose register file depth.
`define MIPS_REG_COUNT 32

// Machine word width.
`define MIPS_XLEN 32

`endif

// ==== design/mips_pkg.sv ====
`default_nettype none

package mips_pkg;

        typedef enum logic [5:0] {
                OP_SPECIAL = 6'h00,     // R-type, decoded by funct.
                OP_J       = 6'h02,
                OP_BEQ     = 6'h04,
                OP_BNE     = 6'h05,
                OP_BLEZ    = 6'h06,
                OP_BGTZ    = 6'h07,
                OP_ADDIU   = 6'h09,
                OP_ANDI    = 6'h0C,
                OP_ORI     = 6'h0D,
                OP_LUI     = 6'h0F,
                OP_LW      = 6'h23,
                OP_SW      = 6'h2B
        } opcode_t;

        typedef enum logic [5:0] {
                F_JR   = 6'h08,
                F_ADDU = 6'h21,
                F_SUBU = 6'h23,
                F_AND  = 6'h24,
                F_OR   = 6'h25,
                F_XOR  = 6'h26,
                F_SLT  = 6'h2A,
                F_SLTU = 6'h2B
        } funct_t;

        typedef enum logic [3:0] {
                ALU_ADD,
                ALU_SUB,
                ALU_AND,
                ALU_OR,
                ALU_XOR,
                ALU_SLT,
                ALU_SLTU,
                ALU_LUI
        } alu_op_t;

        typedef struct packed {
                opcode_t    opcode;
                logic [4:0] rs;
                logic [4:0] rt;
                logic [4:0] rd;
                logic [4:0] shamt;
                funct_t     funct;
        } r_view_t;

        typedef struct packed {
                opcode_t     opcode;
                logic [4:0]  rs;
                logic [4:0]  rt;
                logic [15:0] imm;
        } i_view_t;

        // One fetched word, seen as R-type or I-type.
        typedef union packed {
                r_view_t r;
                i_view_t i;
        } instr_t;

        typedef struct packed {
                logic [31:0] alu_value;         // Also the memory address.
                logic [31:0] store_data;
                logic [4:0]  dest;
                logic        reg_write;
                logic        mem_read;
                logic        mem_write;
                logic        taken;
                logic        halt;
                logic [31:0] target;
        } exec_result_t;

endpackage

`default_nettype wire

// ==== design/mips_dec_if.sv ====
`timescale 1ns/10ps
`default_nettype none

interface mips_dec_if;
        import mips_pkg::*;

        instr_t      instr;
        logic [31:0] rs_value;
        logic [31:0] rt_value;
        logic [31:0] imm_ext;
        alu_op_t     alu_op;
        logic        alu_src_imm;
        logic [4:0]  dest;
        logic        reg_write;
        logic        mem_read;
        logic        mem_write;
        logic        branch;
        logic [1:0]  branch_kind;       // Low opcode bits: beq, bne, blez, bgtz.
        logic        jump;
        logic        jump_reg;

        modport decode (output instr, rs_value, rt_value, imm_ext, alu_op, alu_src_imm,
                dest, reg_write, mem_read, mem_write, branch, branch_kind, jump, jump_reg);

        modport execute (input instr, rs_value, rt_value, imm_ext, alu_op, alu_src_imm,
                dest, reg_write, mem_read, mem_write, branch, branch_kind, jump, jump_reg);

endinterface

`default_nettype wire

// ==== design/mips_decode.sv ====
`timescale 1ns/10ps
`default_nettype none

module mips_decode (
        input  mips_pkg::instr_t instr,
        output logic [4:0]       raddr_a,
        output logic [4:0]       raddr_b,
        input  logic [31:0]      rdata_a,
        input  logic [31:0]      rdata_b,
        mips_dec_if.decode       dec
);
        import mips_pkg::*;

        // rs and rt sit in the same bits in both views.
        assign raddr_a = instr.r.rs;
        assign raddr_b = instr.r.rt;

        assign dec.instr    = instr;
        assign dec.rs_value = rdata_a;
        assign dec.rt_value = rdata_b;

        always_comb begin
                dec.imm_ext     = {{16{instr.i.imm[15]}}, instr.i.imm};
                dec.alu_op      = ALU_ADD;
                dec.alu_src_imm = 1'b0;
                dec.dest        = instr.i.rt;
                dec.reg_write   = 1'b0;
                dec.mem_read    = 1'b0;
                dec.mem_write   = 1'b0;
                dec.branch      = 1'b0;
                dec.branch_kind = instr.i.opcode[1:0];
                dec.jump        = 1'b0;
                dec.jump_reg    = 1'b0;

                case (instr.r.opcode)
                OP_SPECIAL: begin
                        dec.dest      = instr.r.rd;
                        dec.reg_write = 1'b1;
                        case (instr.r.funct)
                        F_ADDU: dec.alu_op = ALU_ADD;
                        F_SUBU: dec.alu_op = ALU_SUB;
                        F_AND:  dec.alu_op = ALU_AND;
                        F_OR:   dec.alu_op = ALU_OR;
                        F_XOR:  dec.alu_op = ALU_XOR;
                        F_SLT:  dec.alu_op = ALU_SLT;
                        F_SLTU: dec.alu_op = ALU_SLTU;
                        F_JR: begin
                                dec.jump_reg  = 1'b1;
                                dec.reg_write = 1'b0;
                        end
                        default: dec.reg_write = 1'b0;  // Shifts and nop write nothing.
                        endcase
                end
                OP_ADDIU: begin
                        dec.alu_src_imm = 1'b1;
                        dec.reg_write   = 1'b1;
                end
                OP_ANDI, OP_ORI: begin
                        dec.imm_ext     = {16'h0000, instr.i.imm};      // Logic ops zero-extend.
                        dec.alu_op      = (instr.i.opcode == OP_ANDI) ? ALU_AND : ALU_OR;
                        dec.alu_src_imm = 1'b1;
                        dec.reg_write   = 1'b1;
                end
                OP_LUI: begin
                        dec.alu_op      = ALU_LUI;
                        dec.alu_src_imm = 1'b1;
                        dec.reg_write   = 1'b1;
                end
                OP_LW: begin
                        dec.alu_src_imm = 1'b1;
                        dec.reg_write   = 1'b1;
                        dec.mem_read    = 1'b1;
                end
                OP_SW: begin
                        dec.alu_src_imm = 1'b1;
                        dec.mem_write   = 1'b1;
                end
                OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ: dec.branch = 1'b1;
                OP_J: dec.jump = 1'b1;
                default: ;
                endcase
        end

endmodule

`default_nettype wire

// ==== design/mips_regfile.sv ====
`timescale 1ns/10ps
`include "mips_config.svh"
`default_nettype none

module mips_regfile (
        input  logic                  clk,
        input  logic                  reset,
        input  logic                  clk_enable,
        input  logic [4:0]            raddr_a,
        input  logic [4:0]            raddr_b,
        input  logic                  we,
        input  logic [4:0]            waddr,
        input  logic [`MIPS_XLEN-1:0] wdata,
        output logic [`MIPS_XLEN-1:0] rdata_a,
        output logic [`MIPS_XLEN-1:0] rdata_b,
        output logic [`MIPS_XLEN-1:0] v0
);

        logic [`MIPS_XLEN-1:0] regs [`MIPS_REG_COUNT];

        always_ff @(posedge clk) begin
                if (reset) begin
                        for (int i = 0; i < `MIPS_REG_COUNT; i++) begin
                                regs[i] <= '0;
                        end
                end else if (clk_enable && we && waddr != 5'd0) begin
                        regs[waddr] <= wdata;   // $zero is never written.
                end
        end

        assign rdata_a = regs[raddr_a];
        assign rdata_b = regs[raddr_b];
        assign v0      = regs[2];

endmodule

`default_nettype wire

// ==== design/mips_execute.sv ====
`timescale 1ns/10ps
`default_nettype none

module mips_execute (
        mips_dec_if.execute            dec,
        input  logic [31:0]            pc_plus4,
        output mips_pkg::exec_result_t res
);
        import mips_pkg::*;

        logic [31:0] op_a;
        logic [31:0] op_b;
        logic [31:0] alu;
        logic        cond;
        logic [31:0] branch_target;
        logic [31:0] jump_target;

        assign op_a = dec.rs_value;
        assign op_b = dec.alu_src_imm ? dec.imm_ext : dec.rt_value;

        always_comb begin
                case (dec.alu_op)
                ALU_ADD:  alu = op_a + op_b;
                ALU_SUB:  alu = op_a - op_b;
                ALU_AND:  alu = op_a & op_b;
                ALU_OR:   alu = op_a | op_b;
                ALU_XOR:  alu = op_a ^ op_b;
                ALU_SLT:  alu = {31'd0, $signed(op_a) < $signed(op_b)};
                ALU_SLTU: alu = {31'd0, op_a < op_b};
                ALU_LUI:  alu = {op_b[15:0], 16'h0000};
                default:  alu = '0;
                endcase
        end

        // Branch conditions compare rs against rt or against zero.
        always_comb begin
                case (dec.branch_kind)
                2'b00:   cond = (dec.rs_value == dec.rt_value);
                2'b01:   cond = (dec.rs_value != dec.rt_value);
                2'b10:   cond = ($signed(dec.rs_value) <= 0);
                default: cond = ($signed(dec.rs_value) > 0);
                endcase
        end

        // Both targets are relative to the delay slot address.
        assign branch_target = pc_plus4 + {dec.imm_ext[29:0], 2'b00};
        assign jump_target   = {pc_plus4[31:28], dec.instr.r[25:0], 2'b00};

        always_comb begin
                res.alu_value  = alu;
                res.store_data = dec.rt_value;
                res.dest       = dec.dest;
                res.reg_write  = dec.reg_write;
                res.mem_read   = dec.mem_read;
                res.mem_write  = dec.mem_write;
                res.taken      = (dec.branch && cond) || dec.jump || dec.jump_reg;
                res.halt       = dec.jump_reg && (dec.rs_value == 32'd0);

                if (dec.jump_reg)
                        res.target = dec.rs_value;
                else if (dec.jump)
                        res.target = jump_target;
                else
                        res.target = branch_target;
        end

endmodule

`default_nettype wire

// ==== design/mips_result.sv ====
`timescale 1ns/10ps
`default_nettype none

module mips_result (
        input  logic                   clk,
        input  logic                   reset,
        input  logic                   clk_enable,
        input  mips_pkg::exec_result_t res,
        input  logic [31:0]            data_readdata,
        output logic [31:0]            data_address,
        output logic                   data_write,
        output logic                   data_read,
        output logic [31:0]            data_writedata,
        output logic                   we,
        output logic [4:0]             waddr,
        output logic [31:0]            wdata,
        output logic                   stall
);

        logic load_wait;        // Second cycle of a load.

        always_ff @(posedge clk) begin
                if (reset)
                        load_wait <= 1'b0;
                else if (clk_enable)
                        load_wait <= res.mem_read && !load_wait;
        end

        // The load address stays valid in both cycles since pc is held.
        assign data_address   = res.alu_value;
        assign data_writedata = res.store_data;
        assign data_write     = clk_enable && res.mem_write;
        assign data_read      = clk_enable && res.mem_read && !load_wait;

        assign stall = res.mem_read && !load_wait;

        // Loads write back only once the read data has arrived.
        assign we    = clk_enable && res.reg_write && !stall;
        assign waddr = res.dest;
        assign wdata = load_wait ? data_readdata : res.alu_value;

endmodule

`default_nettype wire

// ==== design/mips_cpu_harvard.sv ====
`timescale 1ns/10ps
`include "mips_config.svh"
`default_nettype none

module mips_cpu_harvard (
        input  logic                  clk,
        input  logic                  reset,
        output logic                  active,
        output logic [`MIPS_XLEN-1:0] register_v0,
        input  logic                  clk_enable,
        output logic [`MIPS_XLEN-1:0] instr_address,
        input  logic [`MIPS_XLEN-1:0] instr_readdata,
        output logic [`MIPS_XLEN-1:0] data_address,
        output logic                  data_write,
        output logic                  data_read,
        output logic [`MIPS_XLEN-1:0] data_writedata,
        input  logic [`MIPS_XLEN-1:0] data_readdata
);
        import mips_pkg::*;

        logic [`MIPS_XLEN-1:0] pc;
        logic [`MIPS_XLEN-1:0] next_pc;        // Delay slot address or taken target.
        logic                  halt_pending;
        logic                  at_halt;
        logic                  run;
        logic                  stall;

        instr_t                instr;
        exec_result_t          res;
        logic [4:0]            raddr_a;
        logic [4:0]            raddr_b;
        logic [`MIPS_XLEN-1:0] rdata_a;
        logic [`MIPS_XLEN-1:0] rdata_b;
        logic                  we;
        logic [4:0]            waddr;
        logic [`MIPS_XLEN-1:0] wdata;

        assign instr         = instr_readdata;
        assign instr_address = pc;

        // The word fetched from zero after jr $0 never executes.
        assign at_halt = halt_pending && (pc == 32'd0);
        assign run     = clk_enable && active && !reset && !at_halt;

        always_ff @(posedge clk) begin
                if (reset) begin
                        pc           <= `MIPS_RESET_VECTOR;
                        next_pc      <= `MIPS_RESET_VECTOR + 32'd4;
                        halt_pending <= 1'b0;
                        active       <= 1'b1;
                end else if (clk_enable) begin
                        if (at_halt)
                                active <= 1'b0;
                        if (run && !stall) begin
                                pc      <= next_pc;
                                next_pc <= res.taken ? res.target : next_pc + 32'd4;
                                if (res.halt)
                                        halt_pending <= 1'b1;
                        end
                end
        end

        mips_dec_if dec_if ();

        mips_decode u_decode (
                .instr   (instr),
                .raddr_a (raddr_a),
                .raddr_b (raddr_b),
                .rdata_a (rdata_a),
                .rdata_b (rdata_b),
                .dec     (dec_if)
        );

        mips_regfile u_regfile (
                .clk        (clk),
                .reset      (reset),
                .clk_enable (clk_enable),
                .raddr_a    (raddr_a),
                .raddr_b    (raddr_b),
                .we         (we),
                .waddr      (waddr),
                .wdata      (wdata),
                .rdata_a    (rdata_a),
                .rdata_b    (rdata_b),
                .v0         (register_v0)
        );

        mips_execute u_execute (
                .dec      (dec_if),
                .pc_plus4 (pc + 32'd4),
                .res      (res)
        );

        mips_result u_result (
                .clk            (clk),
                .reset          (reset),
                .clk_enable     (run),
                .res            (res),
                .data_readdata  (data_readdata),
                .data_address   (data_address),
                .data_write     (data_write),
                .data_read      (data_read),
                .data_writedata (data_writedata),
                .we             (we),
                .waddr          (waddr),
                .wdata          (wdata),
                .stall          (stall)
        );

endmodule

`default_nettype wire

// ==== sim/mips_cpu_sva.sv ====
`timescale 1ns/10ps
`default_nettype none

module mips_cpu_sva (
        input logic clk,
        input logic reset,
        input logic clk_enable,
        input logic active,
        input logic data_read,
        input logic data_write
);

        assert property (@(posedge clk) !(data_read && data_write))
                else $error("data_read and data_write are high together");

        // Strobes only move while the core runs out of reset.
        assert property (@(posedge clk) (reset || !clk_enable) |-> !(data_read || data_write))
                else $error("memory strobe during reset or with clk_enable low");

        assert property (@(posedge clk) disable iff (reset) !active |=> !active)
                else $error("active rose again without a reset");

endmodule

bind mips_cpu_harvard mips_cpu_sva u_sva (.*);

`default_nettype wire

// ==== sim/mips_cpu_tb.sv ====
`timescale 1ns/10ps
`include "mips_config.svh"
`default_nettype none

module mips_cpu_tb;
        import mips_pkg::*;

        localparam int NUM_PROGS   = 20;
        localparam int PROG_LEN    = 42;        // Words per random program including jr and nop.
        localparam int CYCLE_LIMIT = (NUM_PROGS + 1) * (PROG_LEN * 3 + 20);

        logic         clk;
        logic         reset;
        logic         clk_enable;
        logic         active;
        logic [31:0]  register_v0;
        logic [31:0]  instr_address;
        logic [31:0]  instr_readdata;
        logic [31:0]  data_address;
        logic         data_write;
        logic         data_read;
        logic [31:0]  data_writedata;
        logic [31:0]  data_readdata;
        logic [31:0]  fetch_off;

        logic [31:0]  imem [256];
        logic [31:0]  dmem [64];
        logic [31:0]  model_dmem [64];
        logic [31:0]  model_v0;
        logic [31:0]  exp_trace [$];
        exec_result_t exp_stores [$];
        exec_result_t store_seen;
        logic [31:0]  read_word;
        logic [31:0]  last_pc;
        logic         checking;
        int           trace_pos;
        int           value_errors;
        int           other_errors;
        int           cycles;

        mips_cpu_harvard DUT (.*);

        // Outside the program the instruction port reads nop.
        assign fetch_off      = instr_address - `MIPS_RESET_VECTOR;
        assign instr_readdata = (fetch_off < 32'd1024) ? imem[fetch_off[9:2]] : 32'd0;

        initial begin
                clk = 1'b0;
                forever #50 clk = ~clk;
        end

        always @(posedge clk) begin
                cycles++;
                if (cycles >= CYCLE_LIMIT) begin
                        $display("Timeout: the core did not halt within %0d cycles", CYCLE_LIMIT);
                        $display("Errors: %0d value, %0d other", value_errors, other_errors + 1);
                        $display("RESULT: FAIL");
                        $finish;
                end
        end

        task automatic check_word(input string name, input logic [31:0] exp,
                        input logic [31:0] got);
                if (got !== exp) begin
                        value_errors++;
                        $display("Fail at %0t: %s expected %h, got %h", $time, name, exp, got);
                end
        endtask

        task automatic check_bit(input string name, input logic exp, input logic got);
                if (got !== exp) begin
                        value_errors++;
                        $display("Fail at %0t: %s expected %b, got %b", $time, name, exp, got);
                end
        endtask

        task automatic check_store(input exec_result_t exp, input exec_result_t got);
                check_word("data_address", exp.alu_value, got.alu_value);
                check_word("data_writedata", exp.store_data, got.store_data);
        endtask

        function automatic logic [31:0] encode_i(input logic [5:0] op, input logic [4:0] rs,
                        input logic [4:0] rt, input logic [15:0] imm);
                return {op, rs, rt, imm};
        endfunction

        function automatic logic [31:0] encode_r(input logic [5:0] funct, input logic [4:0] rs,
                        input logic [4:0] rt, input logic [4:0] rd);
                return {6'h00, rs, rt, rd, 5'd0, funct};
        endfunction

        // Data memory, fetch trace and store order are sampled at the committing edge.
        always @(posedge clk) begin
                if (checking && !reset) begin
                        if (active && instr_address !== last_pc) begin
                                if (trace_pos < exp_trace.size()) begin
                                        check_word("instr_address", exp_trace[trace_pos],
                                                instr_address);
                                end else begin
                                        other_errors++;
                                        $display("Fetch at %0t past the end of the model trace",
                                                $time);
                                end
                                trace_pos++;
                                last_pc = instr_address;
                        end
                        if (!clk_enable && (data_read || data_write)) begin
                                other_errors++;
                                $display("Memory strobe at %0t while clk_enable is low", $time);
                        end
                        if (data_write) begin
                                store_seen = '0;
                                store_seen.alu_value  = data_address;
                                store_seen.store_data = data_writedata;
                                if (exp_stores.size() == 0) begin
                                        other_errors++;
                                        $display("Store at %0t that the model never made", $time);
                                end else begin
                                        check_store(exp_stores.pop_front(), store_seen);
                                end
                                dmem[data_address[7:2]] <= data_writedata;
                        end
                        if (data_read)
                                read_word <= dmem[data_address[7:2]];
                end
        end

        always @(negedge clk)
                data_readdata <= read_word;     // One cycle after data_read.

        // ISA model with one delay slot per branch or jump.
        task automatic run_model();
                logic [31:0]  regs [32];
                logic [31:0]  pc;
                logic [31:0]  npc;
                logic [31:0]  w;
                logic [31:0]  a;
                logic [31:0]  b;
                logic [31:0]  simm;
                logic [31:0]  val;
                logic [31:0]  target;
                logic [4:0]   dst;
                logic         wr;
                logic         taken;
                exec_result_t st;

                foreach (regs[i])
                        regs[i] = '0;
                pc  = `MIPS_RESET_VECTOR;
                npc = pc + 32'd4;
                exp_trace.delete();
                exp_stores.delete();
                repeat (4 * PROG_LEN) begin
                        exp_trace.push_back(pc);
                        if (pc == 32'd0)
                                break;
                        w      = imem[8'((pc - `MIPS_RESET_VECTOR) >> 2)];
                        a      = regs[w[25:21]];
                        b      = regs[w[20:16]];
                        simm   = {{16{w[15]}}, w[15:0]};
                        val    = '0;
                        dst    = w[20:16];
                        wr     = 1'b1;
                        taken  = 1'b0;
                        target = npc + (simm << 2);
                        case (w[31:26])
                        OP_SPECIAL: begin
                                dst = w[15:11];
                                case (w[5:0])
                                F_ADDU: val = a + b;
                                F_SUBU: val = a - b;
                                F_AND:  val = a & b;
                                F_OR:   val = a | b;
                                F_XOR:  val = a ^ b;
                                F_SLT:  val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                                F_SLTU: val = (a < b) ? 32'd1 : 32'd0;
                                F_JR: begin
                                        wr     = 1'b0;
                                        taken  = 1'b1;
                                        target = a;
                                end
                                default: wr = 1'b0;
                                endcase
                        end
                        OP_ADDIU: val = a + simm;
                        OP_ANDI:  val = a & {16'h0000, w[15:0]};
                        OP_ORI:   val = a | {16'h0000, w[15:0]};
                        OP_LUI:   val = {w[15:0], 16'h0000};
                        OP_LW: begin
                                val = a + simm;
                                val = model_dmem[val[7:2]];
                        end
                        OP_SW: begin
                                wr            = 1'b0;
                                st            = '0;
                                st.alu_value  = a + simm;
                                st.store_data = b;
                                model_dmem[st.alu_value[7:2]] = b;
                                exp_stores.push_back(st);
                        end
                        default: wr = 1'b0;
                        endcase
                        case (w[31:26])
                        OP_BEQ:  taken = (a == b);
                        OP_BNE:  taken = (a != b);
                        OP_BLEZ: taken = ($signed(a) <= 0);
                        OP_BGTZ: taken = ($signed(a) > 0);
                        default: ;
                        endcase
                        if (wr && dst != 5'd0)
                                regs[dst] = val;
                        pc  = npc;
                        npc = taken ? target : pc + 32'd4;
                end
                model_v0 = regs[2];
        endtask

        // Store 64, load it back and add it to 65 in $2.
        task automatic build_directed_program();
                foreach (imem[i])
                        imem[i] = '0;
                imem[0] = encode_i(OP_ADDIU, 5'd0, 5'd3, 16'd64);
                imem[1] = encode_i(OP_SW, 5'd0, 5'd3, 16'd8);
                imem[2] = encode_i(OP_ADDIU, 5'd0, 5'd2, 16'd65);
                imem[3] = encode_i(OP_LW, 5'd0, 5'd4, 16'd8);
                imem[4] = encode_r(F_ADDU, 5'd2, 5'd4, 5'd2);
                imem[5] = encode_r(F_JR, 5'd0, 5'd0, 5'd0);
        endtask

        task automatic build_random_program();
                funct_t     alu_functs [7] = '{F_ADDU, F_SUBU, F_AND, F_OR, F_XOR, F_SLT, F_SLTU};
                int         last;
                int         kind;
                int         offset;
                logic       prev_branch;
                logic [4:0] rs;
                logic [4:0] rt;
                logic [5:0] op;

                last        = PROG_LEN - 2;
                prev_branch = 1'b0;
                foreach (imem[i])
                        imem[i] = '0;
                for (int i = 0; i < last; i++) begin
                        kind = $urandom % 8;
                        rs   = 5'($urandom % 8);
                        rt   = 5'($urandom % 8);
                        // No branch in a delay slot or right before the final jr.
                        if (kind >= 6 && (prev_branch || i > last - 2))
                                kind = 0;
                        prev_branch = (kind >= 6);
                        case (kind)
                        0: imem[i] = encode_i(OP_ADDIU, rs, rt, 16'($urandom));
                        1: imem[i] = encode_i(OP_LUI, 5'd0, rt, 16'($urandom));
                        2: imem[i] = encode_i(OP_ORI, rs, rt, 16'($urandom));
                        3: imem[i] = encode_r(alu_functs[$urandom % 7], rs, rt, 5'($urandom % 8));
                        4: imem[i] = encode_i(OP_LW, 5'd0, rt, 16'(4 * ($urandom % 64)));
                        5: imem[i] = encode_i(OP_SW, 5'd0, rt, 16'(4 * ($urandom % 64)));
                        default: begin
                                offset = 1 + $urandom % 3;
                                if (i + 1 + offset > last)
                                        offset = last - 1 - i;
                                op = 6'(OP_BEQ) + 6'($urandom % 4);
                                if (op == OP_BLEZ || op == OP_BGTZ)
                                        rt = 5'd0;
                                imem[i] = encode_i(op, rs, rt, 16'(offset));
                        end
                        endcase
                end
                imem[last] = encode_r(F_JR, 5'd0, 5'd0, 5'd0);  // The nop after it is the slot.
        endtask

        task automatic run_program(input bit directed);
                int idle_left;

                checking = 1'b0;
                foreach (dmem[i]) begin
                        dmem[i]       = $urandom;
                        model_dmem[i] = dmem[i];
                end
                run_model();
                trace_pos  = 0;
                last_pc    = 32'hFFFF_FFFF;
                reset      = 1'b1;
                clk_enable = 1'b1;
                repeat (5) @(negedge clk);
                check_word("instr_address", `MIPS_RESET_VECTOR, instr_address);
                check_bit("active", 1'b1, active);
                check_bit("data_read", 1'b0, data_read);
                check_bit("data_write", 1'b0, data_write);
                reset     = 1'b0;
                checking  = 1'b1;
                idle_left = PROG_LEN;
                forever begin
                        @(negedge clk);
                        if (!active)
                                break;
                        if (idle_left > 0 && $urandom % 4 == 0) begin
                                clk_enable = 1'b0;
                                idle_left--;
                        end else begin
                                clk_enable = 1'b1;
                        end
                end
                clk_enable = 1'b1;
                check_word("register_v0", model_v0, register_v0);
                check_word("instr_address", 32'd0, instr_address);
                if (directed)
                        check_word("register_v0", 32'd129, register_v0);
                if (trace_pos != exp_trace.size() || exp_stores.size() != 0) begin
                        other_errors++;
                        $display("Halt at %0t with model fetches or stores still missing", $time);
                end
                for (int i = 0; i < 64; i++)
                        check_word($sformatf("dmem[%0d]", i), model_dmem[i], dmem[i]);
        endtask

        initial begin
                void'($urandom(32'hb539b8e4));
                reset         = 1'b1;
                clk_enable    = 1'b1;
                data_readdata = '0;
                read_word     = '0;
                checking      = 1'b0;
                build_directed_program();
                run_program(1'b1);
                repeat (NUM_PROGS) begin
                        build_random_program();
                        run_program(1'b0);
                end
                $display("Errors: %0d value, %0d other", value_errors, other_errors);
                if (value_errors == 0 && other_errors == 0)
                        $display("RESULT: PASS");
                else
                        $display("RESULT: FAIL");
                $finish;
        end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+design
design/mips_pkg.sv
design/mips_dec_if.sv
design/mips_decode.sv
design/mips_regfile.sv
design/mips_execute.sv
design/mips_result.sv
design/mips_cpu_harvard.sv
sim/mips_cpu_sva.sv
sim/mips_cpu_tb.sv
